// File: hw/raster_dcr.sv
`timescale 1ns/100ps

module raster_dcr (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      write_valid,
    input  logic [raster_dcr_pkg::DCR_ADDR_BITS-1:0]  write_addr,
    input  logic [raster_dcr_pkg::DCR_DATA_BITS-1:0]  write_data,
    output logic [raster_dims_pkg::DIM_BITS-1:0]      xmin,
    output logic [raster_dims_pkg::DIM_BITS-1:0]      xmax,
    output logic [raster_dims_pkg::DIM_BITS-1:0]      ymin,
    output logic [raster_dims_pkg::DIM_BITS-1:0]      ymax
);
    localparam int DB = raster_dims_pkg::DIM_BITS;
    localparam logic [31:0] RST = raster_dcr_pkg::SCISSOR_RESET;

    always_ff @(posedge clk) begin
        if (reset) begin
            xmin <= RST[DB-1:0];
            xmax <= RST[16 +: DB];
            ymin <= RST[DB-1:0];
            ymax <= RST[16 +: DB];
        end else if (write_valid) begin
            case (write_addr)
                raster_dcr_pkg::DCR_SCISSOR_X: begin
                    xmin <= write_data[DB-1:0];
                    xmax <= write_data[16 +: DB];
                end
                raster_dcr_pkg::DCR_SCISSOR_Y: begin
                    ymin <= write_data[DB-1:0];
                    ymax <= write_data[16 +: DB];
                end
                default: ;  // other addresses ignored
            endcase
        end
    end

endmodule

// File: hw/raster_dcr_pkg.sv
package raster_dcr_pkg;

    localparam int DCR_ADDR_BITS = 8;
    localparam int DCR_DATA_BITS = 32;

    // min in [15:0], max in [31:16]
    localparam logic [DCR_ADDR_BITS-1:0] DCR_SCISSOR_X = 8'h10;
    localparam logic [DCR_ADDR_BITS-1:0] DCR_SCISSOR_Y = 8'h11;

    // whole coordinate range, same layout as a write
    localparam logic [DCR_DATA_BITS-1:0] SCISSOR_RESET = {
        16'((1 << raster_dims_pkg::DIM_BITS) - 1),
        16'd0
    };

endpackage

// File: hw/raster_dims_pkg.sv
package raster_dims_pkg;

    // pixel coordinates and primitive ids
    localparam int DIM_BITS = 11;
    localparam int PID_BITS = 8;

    // one signed edge word: a, b, c or an evaluated value
    localparam int EDGE_BITS = 32;

    // coverage lanes of a 2x2 quad
    localparam int MASK_BITS = 4;

    //////////////////////////////////////////////////////////////////////
    // tile geometry

    localparam int TILE_BITS = 3;      // 8x8 pixels, 16 quads

    // multiply stage, then add stage
    localparam int EDGE_LATENCY = 2;

endpackage

// File: hw/raster_dispatch.sv
`timescale 1ns/100ps

module raster_dispatch #(
    parameter int NUM_SLICES = 2
) (
    input  logic clk,
    input  logic reset,
    tile_if.dst  in,
    tile_if.src  out [NUM_SLICES],
    output logic busy
);
    localparam int SEL_BITS = (NUM_SLICES > 1) ? $clog2(NUM_SLICES) : 1;

    logic                                                   full;
    logic [raster_dims_pkg::DIM_BITS-1:0]                   hold_xloc;
    logic [raster_dims_pkg::DIM_BITS-1:0]                   hold_yloc;
    logic [raster_dims_pkg::PID_BITS-1:0]                   hold_pid;
    logic [2:0][2:0][raster_dims_pkg::EDGE_BITS-1:0]        hold_edges;
    logic [NUM_SLICES-1:0]                                  slice_ready;
    logic [SEL_BITS-1:0]                                    last;
    logic [SEL_BITS-1:0]                                    pick;
    logic                                                   found;
    logic                                                   fire_out;

    // next ready slice after the last one served
    always_comb begin
        int idx;
        found = 1'b0;
        pick  = last;
        for (int j = 1; j <= NUM_SLICES; j++) begin
            idx = (int'(last) + j) % NUM_SLICES;
            if (!found && slice_ready[idx]) begin
                found = 1'b1;
                pick  = SEL_BITS'(idx);
            end
        end
    end

    assign fire_out = full && found;
    assign in.ready = ~full || fire_out;   // refill in the emptying cycle
    assign busy     = full;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
            last <= SEL_BITS'(NUM_SLICES - 1);
        end else begin
            if (in.valid && in.ready)
                full <= 1'b1;
            else if (fire_out)
                full <= 1'b0;
            if (fire_out)
                last <= pick;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.ready) begin
            hold_xloc  <= in.xloc;
            hold_yloc  <= in.yloc;
            hold_pid   <= in.pid;
            hold_edges <= in.edges;
        end
    end

    for (genvar i = 0; i < NUM_SLICES; i++) begin : g_out
        assign slice_ready[i] = out[i].ready;
        assign out[i].valid   = fire_out && (pick == SEL_BITS'(i));
        assign out[i].xloc    = hold_xloc;
        assign out[i].yloc    = hold_yloc;
        assign out[i].pid     = hold_pid;
        assign out[i].edges   = hold_edges;
    end

endmodule

// File: hw/raster_edge_setup.sv
`timescale 1ns/100ps

module raster_edge_setup (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            in_valid,
    output logic                                            in_ready,
    input  logic [raster_dims_pkg::DIM_BITS-1:0]            xloc,
    input  logic [raster_dims_pkg::DIM_BITS-1:0]            yloc,
    input  logic [raster_dims_pkg::PID_BITS-1:0]            pid,
    input  logic [2:0][2:0][raster_dims_pkg::EDGE_BITS-1:0] edges,
    tile_if.src                                             out,
    output logic                                            busy
);
    localparam int L  = raster_dims_pkg::EDGE_LATENCY;
    localparam int EB = raster_dims_pkg::EDGE_BITS;

    logic             running;
    logic             enable;
    logic [L-1:0]     vld;

    // stage 1: products
    logic [2:0][EB-1:0]                      s1_ax;
    logic [2:0][EB-1:0]                      s1_by;
    logic [2:0][2:0][EB-1:0]                 s1_edges;
    logic [raster_dims_pkg::DIM_BITS-1:0]    s1_x;
    logic [raster_dims_pkg::DIM_BITS-1:0]    s1_y;
    logic [raster_dims_pkg::PID_BITS-1:0]    s1_pid;

    // stage 2: output
    logic [2:0][2:0][EB-1:0]                 s2_edges;
    logic [raster_dims_pkg::DIM_BITS-1:0]    s2_x;
    logic [raster_dims_pkg::DIM_BITS-1:0]    s2_y;
    logic [raster_dims_pkg::PID_BITS-1:0]    s2_pid;

    assign enable   = ~(vld[L-1] && ~out.ready);   // freeze whole pipe
    assign in_ready = running && enable;
    assign busy     = |vld;

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            vld     <= '0;
        end else begin
            running <= 1'b1;
            if (enable)
                vld <= {vld[L-2:0], in_valid && in_ready};
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            for (int k = 0; k < 3; k++) begin
                s1_ax[k] <= $signed(edges[k][0]) * $signed({1'b0, xloc});
                s1_by[k] <= $signed(edges[k][1]) * $signed({1'b0, yloc});
                s2_edges[k][0] <= s1_edges[k][0];
                s2_edges[k][1] <= s1_edges[k][1];
                s2_edges[k][2] <= s1_ax[k] + s1_by[k] + s1_edges[k][2];  // c replaced
            end
            s1_edges <= edges;
            s1_x     <= xloc;
            s1_y     <= yloc;
            s1_pid   <= pid;
            s2_x     <= s1_x;
            s2_y     <= s1_y;
            s2_pid   <= s1_pid;
        end
    end

    assign out.valid = vld[L-1];
    assign out.xloc  = s2_x;
    assign out.yloc  = s2_y;
    assign out.pid   = s2_pid;
    assign out.edges = s2_edges;

endmodule

// File: hw/raster_ifs.sv
`timescale 1ns/100ps

// tile after edge evaluation; edges[k] = {a, b, value at origin}
interface tile_if;
    logic                                        valid;
    logic                                        ready;
    logic [raster_dims_pkg::DIM_BITS-1:0]        xloc;
    logic [raster_dims_pkg::DIM_BITS-1:0]        yloc;
    logic [raster_dims_pkg::PID_BITS-1:0]        pid;
    logic [2:0][2:0][raster_dims_pkg::EDGE_BITS-1:0] edges;

    modport src (output valid, xloc, yloc, pid, edges, input ready);
    modport dst (input valid, xloc, yloc, pid, edges, output ready);
endinterface

//////////////////////////////////////////////////////////////////////
// one quad stamp from a slice

interface stamp_if;
    logic                                  valid;
    logic                                  ready;
    logic [raster_dims_pkg::DIM_BITS-1:0]  x;
    logic [raster_dims_pkg::DIM_BITS-1:0]  y;
    logic [raster_dims_pkg::MASK_BITS-1:0] mask;
    logic [raster_dims_pkg::PID_BITS-1:0]  pid;
    logic                                  busy;   // slice holds a tile

    modport src (output valid, x, y, mask, pid, busy, input ready);
    modport dst (input valid, x, y, mask, pid, busy, output ready);
endinterface

// File: hw/raster_slice.sv
`timescale 1ns/100ps

module raster_slice #(
    parameter int TILE_LOGSIZE = 3
) (
    input  logic                                 clk,
    input  logic                                 reset,
    tile_if.dst                                  tile,
    input  logic [raster_dims_pkg::DIM_BITS-1:0] xmin,
    input  logic [raster_dims_pkg::DIM_BITS-1:0] xmax,
    input  logic [raster_dims_pkg::DIM_BITS-1:0] ymin,
    input  logic [raster_dims_pkg::DIM_BITS-1:0] ymax,
    stamp_if.src                                 stamp
);
    localparam int DB    = raster_dims_pkg::DIM_BITS;
    localparam int EB    = raster_dims_pkg::EDGE_BITS;
    localparam int QBITS = TILE_LOGSIZE - 1;   // quads per tile side

    logic                                 walking;
    logic                                 step;
    logic [QBITS-1:0]                     qx;
    logic [QBITS-1:0]                     qy;
    logic [DB-1:0]                        tx;
    logic [DB-1:0]                        ty;
    logic [raster_dims_pkg::PID_BITS-1:0] pid;
    logic [2:0][EB-1:0]                   ea;
    logic [2:0][EB-1:0]                   eb;
    logic [2:0][EB-1:0]                   row_e;
    logic [2:0][EB-1:0]                   cur_e;
    logic [raster_dims_pkg::MASK_BITS-1:0] mask;

    //////////////////////////////////////////////////////////////////////
    // coverage of the current quad

    always_comb begin
        logic [DB-1:0] px;
        logic [DB-1:0] py;
        logic [EB-1:0] ev;
        logic          cov;
        for (int p = 0; p < 4; p++) begin
            px  = tx + DB'({qx, p[0]});
            py  = ty + DB'({qy, p[1]});
            cov = 1'b1;
            for (int k = 0; k < 3; k++) begin
                ev  = cur_e[k] + (p[0] ? ea[k] : '0) + (p[1] ? eb[k] : '0);
                cov = cov && ~ev[EB-1];   // edge value >= 0
            end
            mask[p] = cov && (px >= xmin) && (px < xmax) && (py >= ymin) && (py < ymax);
        end
    end

    // empty quads pass without a stamp
    assign step = walking && ((mask == '0) || stamp.ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            walking <= 1'b0;
        end else if (tile.valid && tile.ready) begin
            walking <= 1'b1;
        end else if (step && (&qx) && (&qy)) begin
            walking <= 1'b0;   // last quad
        end
    end

    always_ff @(posedge clk) begin
        if (tile.valid && tile.ready) begin
            tx  <= tile.xloc;
            ty  <= tile.yloc;
            pid <= tile.pid;
            qx  <= '0;
            qy  <= '0;
            for (int k = 0; k < 3; k++) begin
                ea[k]    <= tile.edges[k][0];
                eb[k]    <= tile.edges[k][1];
                row_e[k] <= tile.edges[k][2];
                cur_e[k] <= tile.edges[k][2];
            end
        end else if (step) begin
            if (&qx) begin
                qx <= '0;
                qy <= qy + 1'b1;
                for (int k = 0; k < 3; k++) begin
                    row_e[k] <= row_e[k] + (eb[k] << 1);   // next quad row
                    cur_e[k] <= row_e[k] + (eb[k] << 1);
                end
            end else begin
                qx <= qx + 1'b1;
                for (int k = 0; k < 3; k++)
                    cur_e[k] <= cur_e[k] + (ea[k] << 1);
            end
        end
    end

    assign tile.ready  = ~walking;
    assign stamp.valid = walking && (mask != '0);
    assign stamp.x     = tx + DB'({qx, 1'b0});
    assign stamp.y     = ty + DB'({qy, 1'b0});
    assign stamp.mask  = mask;
    assign stamp.pid   = pid;
    assign stamp.busy  = walking;

endmodule

// File: hw/raster_stamp_merge.sv
`timescale 1ns/100ps

module raster_stamp_merge #(
    parameter int NUM_SLICES = 2
) (
    input  logic                                  clk,
    input  logic                                  reset,
    stamp_if.dst                                  stamps [NUM_SLICES],
    input  logic                                  edge_busy,
    input  logic                                  dispatch_busy,
    output logic                                  out_valid,
    input  logic                                  out_ready,
    output logic [raster_dims_pkg::DIM_BITS-1:0]  out_x,
    output logic [raster_dims_pkg::DIM_BITS-1:0]  out_y,
    output logic [raster_dims_pkg::MASK_BITS-1:0] out_mask,
    output logic [raster_dims_pkg::PID_BITS-1:0]  out_pid,
    output logic                                  done
);
    localparam int SEL_BITS = (NUM_SLICES > 1) ? $clog2(NUM_SLICES) : 1;

    logic                                                  running;
    logic                                                  load;
    logic                                                  found;
    logic [SEL_BITS-1:0]                                   last;
    logic [SEL_BITS-1:0]                                   pick;
    logic [NUM_SLICES-1:0]                                 s_valid;
    logic [NUM_SLICES-1:0]                                 s_busy;
    logic [NUM_SLICES-1:0][raster_dims_pkg::DIM_BITS-1:0]  s_x;
    logic [NUM_SLICES-1:0][raster_dims_pkg::DIM_BITS-1:0]  s_y;
    logic [NUM_SLICES-1:0][raster_dims_pkg::MASK_BITS-1:0] s_mask;
    logic [NUM_SLICES-1:0][raster_dims_pkg::PID_BITS-1:0]  s_pid;

    for (genvar i = 0; i < NUM_SLICES; i++) begin : g_in
        assign s_valid[i]      = stamps[i].valid;
        assign s_busy[i]       = stamps[i].busy;
        assign s_x[i]          = stamps[i].x;
        assign s_y[i]          = stamps[i].y;
        assign s_mask[i]       = stamps[i].mask;
        assign s_pid[i]        = stamps[i].pid;
        assign stamps[i].ready = load && found && (pick == SEL_BITS'(i));
    end

    // round-robin over slices with a stamp
    always_comb begin
        int idx;
        found = 1'b0;
        pick  = last;
        for (int j = 1; j <= NUM_SLICES; j++) begin
            idx = (int'(last) + j) % NUM_SLICES;
            if (!found && s_valid[idx]) begin
                found = 1'b1;
                pick  = SEL_BITS'(idx);
            end
        end
    end

    assign load = ~out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            running   <= 1'b0;
            out_valid <= 1'b0;
            last      <= SEL_BITS'(NUM_SLICES - 1);
        end else begin
            running <= 1'b1;
            if (load)
                out_valid <= found;
            if (load && found)
                last <= pick;
        end
    end

    always_ff @(posedge clk) begin
        if (load && found) begin
            out_x    <= s_x[pick];
            out_y    <= s_y[pick];
            out_mask <= s_mask[pick];
            out_pid  <= s_pid[pick];
        end
    end

    // nothing in flight anywhere
    assign done = running && ~(|s_valid) && ~(|s_busy) && ~edge_busy
                  && ~dispatch_busy && ~out_valid;

endmodule

// File: hw/raster_unit.sv
`timescale 1ns/100ps

module raster_unit #(
    parameter int NUM_SLICES   = 2,
    parameter int TILE_LOGSIZE = raster_dims_pkg::TILE_BITS
) (
    input  logic                                            clk,
    input  logic                                            reset,

    input  logic                                            dcr_write_valid,
    input  logic [raster_dcr_pkg::DCR_ADDR_BITS-1:0]        dcr_write_addr,
    input  logic [raster_dcr_pkg::DCR_DATA_BITS-1:0]        dcr_write_data,

    // prim_edges[k] = {c, b, a} of edge k, a in the low word
    input  logic                                            prim_valid,
    output logic                                            prim_ready,
    input  logic [raster_dims_pkg::DIM_BITS-1:0]            prim_xloc,
    input  logic [raster_dims_pkg::DIM_BITS-1:0]            prim_yloc,
    input  logic [raster_dims_pkg::PID_BITS-1:0]            prim_pid,
    input  logic [2:0][2:0][raster_dims_pkg::EDGE_BITS-1:0] prim_edges,

    output logic                                            stamp_valid,
    input  logic                                            stamp_ready,
    output logic [raster_dims_pkg::DIM_BITS-1:0]            stamp_x,
    output logic [raster_dims_pkg::DIM_BITS-1:0]            stamp_y,
    output logic [raster_dims_pkg::MASK_BITS-1:0]           stamp_mask,
    output logic [raster_dims_pkg::PID_BITS-1:0]            stamp_pid,
    output logic                                            done
);
    logic [raster_dims_pkg::DIM_BITS-1:0] xmin;
    logic [raster_dims_pkg::DIM_BITS-1:0] xmax;
    logic [raster_dims_pkg::DIM_BITS-1:0] ymin;
    logic [raster_dims_pkg::DIM_BITS-1:0] ymax;
    logic                                 edge_busy;
    logic                                 dispatch_busy;

    tile_if  edge_tile ();
    tile_if  slice_tile [NUM_SLICES] ();
    stamp_if slice_stamp [NUM_SLICES] ();

    raster_dcr dcr (
        .clk         (clk),
        .reset       (reset),
        .write_valid (dcr_write_valid),
        .write_addr  (dcr_write_addr),
        .write_data  (dcr_write_data),
        .xmin        (xmin),
        .xmax        (xmax),
        .ymin        (ymin),
        .ymax        (ymax)
    );

    raster_edge_setup edge_setup (
        .clk      (clk),
        .reset    (reset),
        .in_valid (prim_valid),
        .in_ready (prim_ready),
        .xloc     (prim_xloc),
        .yloc     (prim_yloc),
        .pid      (prim_pid),
        .edges    (prim_edges),
        .out      (edge_tile),
        .busy     (edge_busy)
    );

    raster_dispatch #(
        .NUM_SLICES (NUM_SLICES)
    ) dispatch (
        .clk   (clk),
        .reset (reset),
        .in    (edge_tile),
        .out   (slice_tile),
        .busy  (dispatch_busy)
    );

    //////////////////////////////////////////////////////////////////////
    // slices

    for (genvar i = 0; i < NUM_SLICES; i++) begin : g_slice
        raster_slice #(
            .TILE_LOGSIZE (TILE_LOGSIZE)
        ) slice_inst (
            .clk   (clk),
            .reset (reset),
            .tile  (slice_tile[i]),
            .xmin  (xmin),
            .xmax  (xmax),
            .ymin  (ymin),
            .ymax  (ymax),
            .stamp (slice_stamp[i])
        );
    end

    raster_stamp_merge #(
        .NUM_SLICES (NUM_SLICES)
    ) merge (
        .clk           (clk),
        .reset         (reset),
        .stamps        (slice_stamp),
        .edge_busy     (edge_busy),
        .dispatch_busy (dispatch_busy),
        .out_valid     (stamp_valid),
        .out_ready     (stamp_ready),
        .out_x         (stamp_x),
        .out_y         (stamp_y),
        .out_mask      (stamp_mask),
        .out_pid       (stamp_pid),
        .done          (done)
    );

endmodule

// File: run.sh
#!/bin/sh
# build and run the raster testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module raster_tb -f vlog.f -o raster_sim &&
./obj_dir/raster_sim || exit 1

// File: tests/raster_clk_gen.sv
`timescale 1ns/100ps

module raster_clk_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;   // released away from the sampling edge
    end
endmodule

// File: tests/raster_props.sv
`timescale 1ns/100ps

module raster_props (
    input logic                                  clk,
    input logic                                  reset,
    input logic                                  prim_valid,
    input logic                                  prim_ready,
    input logic                                  stamp_valid,
    input logic                                  stamp_ready,
    input logic [raster_dims_pkg::DIM_BITS-1:0]  stamp_x,
    input logic [raster_dims_pkg::DIM_BITS-1:0]  stamp_y,
    input logic [raster_dims_pkg::MASK_BITS-1:0] stamp_mask,
    input logic [raster_dims_pkg::PID_BITS-1:0]  stamp_pid,
    input logic                                  done
);
    // stalled stamp keeps valid and data
    stall_holds: assert property (@(posedge clk) disable iff (reset)
        stamp_valid && !stamp_ready |=> stamp_valid && $stable(stamp_x) && $stable(stamp_y)
            && $stable(stamp_mask) && $stable(stamp_pid))
        else $error("stamp output changed while stalled");

    quiet_in_reset: assert property (@(posedge clk)
        reset |-> !stamp_valid && !prim_ready && !done)
        else $error("output active during reset");

    done_excludes_stamp: assert property (@(posedge clk) disable iff (reset)
        !(done && stamp_valid))
        else $error("done high with a stamp pending");

    busy_after_prim: assert property (@(posedge clk) disable iff (reset)
        prim_valid && prim_ready |=> !done)
        else $error("done high right after a tile was accepted");
endmodule

bind raster_unit raster_props props (
    .clk         (clk),
    .reset       (reset),
    .prim_valid  (prim_valid),
    .prim_ready  (prim_ready),
    .stamp_valid (stamp_valid),
    .stamp_ready (stamp_ready),
    .stamp_x     (stamp_x),
    .stamp_y     (stamp_y),
    .stamp_mask  (stamp_mask),
    .stamp_pid   (stamp_pid),
    .done        (done)
);

// File: tests/raster_tb.sv
`timescale 1ns/100ps

module raster_tb;
    localparam int DB       = raster_dims_pkg::DIM_BITS;
    localparam int PB       = raster_dims_pkg::PID_BITS;
    localparam int EB       = raster_dims_pkg::EDGE_BITS;
    localparam int TIMEOUT  = 4000;   // cycles per wait
    localparam int NUM_PIDS = 24;

    logic                                      clk;
    logic                                      reset;
    logic                                      dcr_write_valid;
    logic [raster_dcr_pkg::DCR_ADDR_BITS-1:0]  dcr_write_addr;
    logic [raster_dcr_pkg::DCR_DATA_BITS-1:0]  dcr_write_data;
    logic                                      prim_valid;
    logic                                      prim_ready;
    logic [DB-1:0]                             prim_xloc;
    logic [DB-1:0]                             prim_yloc;
    logic [PB-1:0]                             prim_pid;
    logic [2:0][2:0][EB-1:0]                   prim_edges;
    logic                                      stamp_valid;
    logic                                      stamp_ready;
    logic [DB-1:0]                             stamp_x;
    logic [DB-1:0]                             stamp_y;
    logic [raster_dims_pkg::MASK_BITS-1:0]     stamp_mask;
    logic [PB-1:0]                             stamp_pid;
    logic                                      done;

    // reference model state by pid
    int         edge_a [NUM_PIDS][3];
    int         edge_b [NUM_PIDS][3];
    int         edge_c [NUM_PIDS][3];
    int         tile_x [NUM_PIDS];
    int         tile_y [NUM_PIDS];
    logic [3:0] exp_mask [NUM_PIDS][16];
    int         got [NUM_PIDS][16];
    bit         sent [NUM_PIDS];
    int         sc_xmin;
    int         sc_xmax;
    int         sc_ymin;
    int         sc_ymax;
    bit         scissor_phase;

    raster_clk_gen #(.PERIOD(40), .RESET_CYCLES(10)) clk_gen (.clk(clk), .reset(reset));

    raster_unit #(
        .NUM_SLICES   (2),
        .TILE_LOGSIZE (3)
    ) DUT (
        .clk             (clk),
        .reset           (reset),
        .dcr_write_valid (dcr_write_valid),
        .dcr_write_addr  (dcr_write_addr),
        .dcr_write_data  (dcr_write_data),
        .prim_valid      (prim_valid),
        .prim_ready      (prim_ready),
        .prim_xloc       (prim_xloc),
        .prim_yloc       (prim_yloc),
        .prim_pid        (prim_pid),
        .prim_edges      (prim_edges),
        .stamp_valid     (stamp_valid),
        .stamp_ready     (stamp_ready),
        .stamp_x         (stamp_x),
        .stamp_y         (stamp_y),
        .stamp_mask      (stamp_mask),
        .stamp_pid       (stamp_pid),
        .done            (done)
    );

    task automatic report_error(string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "check failed");
    endtask

    task automatic report_timeout(string what);
        $display("timed out after %0d cycles waiting for %s", TIMEOUT, what);
        $display("Errors found");
        $fatal(1, "timeout");
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model

    function automatic bit pixel_covered(int pid, int px, int py);
        bit cov;
        cov = (px >= sc_xmin) && (px < sc_xmax) && (py >= sc_ymin) && (py < sc_ymax);
        for (int k = 0; k < 3; k++)
            if (edge_a[pid][k] * px + edge_b[pid][k] * py + edge_c[pid][k] < 0)
                cov = 1'b0;
        return cov;
    endfunction

    task automatic make_random_tile(int pid);
        int cx;
        int cy;
        tile_x[pid] = 8 * int'($urandom_range(0, 63));
        tile_y[pid] = 8 * int'($urandom_range(0, 63));
        for (int k = 0; k < 3; k++) begin
            if ($urandom_range(0, 3) == 0) begin
                edge_a[pid][k] = 0;   // edge that covers everything
                edge_b[pid][k] = 0;
                edge_c[pid][k] = 1;
            end else begin
                cx = tile_x[pid] + int'($urandom_range(0, 7));
                cy = tile_y[pid] + int'($urandom_range(0, 7));
                edge_a[pid][k] = int'($urandom_range(0, 16)) - 8;
                edge_b[pid][k] = int'($urandom_range(0, 16)) - 8;
                edge_c[pid][k] = int'($urandom_range(0, 8)) - 4
                                 - (edge_a[pid][k] * cx + edge_b[pid][k] * cy);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus

    task automatic set_scissor(int xmin, int xmax, int ymin, int ymax);
        sc_xmin = xmin;
        sc_xmax = xmax;
        sc_ymin = ymin;
        sc_ymax = ymax;
        @(negedge clk);
        dcr_write_valid = 1'b1;
        dcr_write_addr  = raster_dcr_pkg::DCR_SCISSOR_X;
        dcr_write_data  = {16'(xmax), 16'(xmin)};
        @(negedge clk);
        dcr_write_addr  = raster_dcr_pkg::DCR_SCISSOR_Y;
        dcr_write_data  = {16'(ymax), 16'(ymin)};
        @(negedge clk);
        dcr_write_valid = 1'b0;
    endtask

    task automatic send_tile(int pid);
        int waited;
        for (int q = 0; q < 16; q++) begin
            for (int p = 0; p < 4; p++)
                exp_mask[pid][q][p] = pixel_covered(pid, tile_x[pid] + 2 * (q % 4) + p % 2,
                                                    tile_y[pid] + 2 * (q / 4) + p / 2);
            got[pid][q] = 0;
        end
        sent[pid] = 1'b1;
        @(negedge clk);
        prim_valid = 1'b1;
        prim_xloc  = DB'(tile_x[pid]);
        prim_yloc  = DB'(tile_y[pid]);
        prim_pid   = PB'(pid);
        for (int k = 0; k < 3; k++) begin
            prim_edges[k][0] = edge_a[pid][k];
            prim_edges[k][1] = edge_b[pid][k];
            prim_edges[k][2] = edge_c[pid][k];
        end
        waited = 0;
        while (!prim_ready) begin
            waited++;
            if (waited > TIMEOUT)
                report_timeout("prim_ready");
            @(negedge clk);
        end
        @(negedge clk);   // accepted on the edge just passed
        prim_valid = 1'b0;
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!done) begin
            waited++;
            if (waited > TIMEOUT)
                report_timeout("done");
            @(negedge clk);
        end
    endtask

    task automatic check_completeness();
        for (int pid = 0; pid < NUM_PIDS; pid++)
            for (int q = 0; q < 16; q++)
                if (sent[pid])
                    assert (got[pid][q] == ((exp_mask[pid][q] != 4'd0) ? 1 : 0))
                    else report_error($sformatf("pid %0d quad %0d received %0d times",
                                                pid, q, got[pid][q]));
    endtask

    // called before the edge on which the stamp transfers
    task automatic check_stamp();
        int pid;
        int dx;
        int dy;
        int q;
        pid = int'(stamp_pid);
        assert (pid < NUM_PIDS && sent[pid])
        else report_error($sformatf("stamp for unknown pid %0d", pid));
        if (scissor_phase)
            for (int p = 0; p < 4; p++)
                if (stamp_mask[p])
                    assert (int'(stamp_x) + p % 2 >= sc_xmin && int'(stamp_x) + p % 2 < sc_xmax
                            && int'(stamp_y) + p / 2 >= sc_ymin
                            && int'(stamp_y) + p / 2 < sc_ymax)
                    else report_error($sformatf("pid %0d mask bit %0d outside scissor", pid, p));
        dx = int'(stamp_x) - tile_x[pid];
        dy = int'(stamp_y) - tile_y[pid];
        assert (dx >= 0 && dx < 8 && dx % 2 == 0 && dy >= 0 && dy < 8 && dy % 2 == 0)
        else report_error($sformatf("pid %0d stamp at %0d,%0d outside its tile",
                                    pid, stamp_x, stamp_y));
        q = (dy / 2) * 4 + dx / 2;
        assert (stamp_mask == exp_mask[pid][q])
        else report_error($sformatf("pid %0d quad %0d mask %b expected %b",
                                    pid, q, stamp_mask, exp_mask[pid][q]));
        assert (got[pid][q] == 0)
        else report_error($sformatf("pid %0d quad %0d received twice", pid, q));
        got[pid][q]++;
    endtask

    always @(negedge clk) begin
        stamp_ready = ($urandom_range(0, 3) != 0);   // 1 in 4 cycles stalled
        if (!reset && stamp_valid && stamp_ready)
            check_stamp();
    end

    initial begin
        int waited;
        void'($urandom(32'h5ea3_81d3));
        dcr_write_valid = 1'b0;
        dcr_write_addr  = '0;
        dcr_write_data  = '0;
        prim_valid      = 1'b0;
        prim_xloc       = '0;
        prim_yloc       = '0;
        prim_pid        = '0;
        prim_edges      = '0;
        stamp_ready     = 1'b0;
        sc_xmin         = 0;
        sc_xmax         = 2047;
        sc_ymin         = 0;
        sc_ymax         = 2047;
        scissor_phase   = 1'b0;

        waited = 0;
        @(negedge clk);
        while (reset) begin
            waited++;
            if (waited > TIMEOUT)
                report_timeout("reset release");
            @(negedge clk);
        end

        // scissor cuts through four fully covered tiles
        set_scissor(3, 13, 5, 11);
        scissor_phase = 1'b1;
        for (int pid = 0; pid < 4; pid++) begin
            tile_x[pid] = 8 * (pid % 2);
            tile_y[pid] = 8 * (pid / 2);
            for (int k = 0; k < 3; k++) begin
                edge_a[pid][k] = 0;
                edge_b[pid][k] = 0;
                edge_c[pid][k] = 0;
            end
            send_tile(pid);
        end
        wait_done();
        check_completeness();
        scissor_phase = 1'b0;

        set_scissor(0, 2047, 0, 2047);
        for (int pid = 4; pid < NUM_PIDS; pid++) begin
            make_random_tile(pid);
            send_tile(pid);
        end
        wait_done();
        check_completeness();

        $display("No errors");
        $finish;
    end
endmodule

// File: vlog.f
hw/raster_dims_pkg.sv
hw/raster_dcr_pkg.sv
hw/raster_ifs.sv
hw/raster_dcr.sv
hw/raster_edge_setup.sv
hw/raster_dispatch.sv
hw/raster_slice.sv
hw/raster_stamp_merge.sv
hw/raster_unit.sv
tests/raster_clk_gen.sv
tests/raster_props.sv
tests/raster_tb.sv
